// File: sources.f
+incdir+common
common/blimp_pkg.sv
source/fetch_unit.sv
decode_issue/decode_issue_unit.sv
source/alu_unit.sv
source/multiplier_unit.sv
writeback_commit/writeback_commit_unit.sv
source/blimp_top.sv
verification/blimp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the blimp testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module blimp_tb -f sources.f \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vblimp_tb > sim.log 2>&1
grep -q "Regression passed" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: verification/blimp_tb.sv
// --------------------
// Testbench for the blimp core
// Instruction memory model, directed and random program
// Reference model, trace checker, timeout
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module blimp_tb;

  logic                            clk;
  logic                            rst;
  logic                            mem_req_val;
  logic                            mem_req_rdy;
  logic [`BLIMP_XLEN-1:0]          mem_req_addr;
  logic                            mem_resp_val;
  logic                            mem_resp_rdy;
  logic [`BLIMP_XLEN-1:0]          mem_resp_data;
  logic                            trace_val;
  logic [`BLIMP_XLEN-1:0]          trace_pc;
  logic [`BLIMP_REG_ADDR_BITS-1:0] trace_waddr;
  logic [`BLIMP_XLEN-1:0]          trace_wdata;
  logic                            trace_wen;

  // Program image and test segments
  logic [31:0] prog [$];
  string       test_names [$];
  int          test_last [$];

  // Memory model state
  logic [31:0] pend_addr [$];
  int          pend_delay [$];
  logic        resp_busy;

  // Checker state
  logic [31:0] ref_regs [`BLIMP_NUM_REGS];
  logic [31:0] exp_pc;
  logic [31:0] exp_wdata;
  logic [4:0]  exp_waddr;
  logic        exp_wen;
  int          commit_count;
  int          cur_test;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;
  logic        done;

  blimp_top uut (.*);

  // --------------------
  // Encoding helpers
  // --------------------
  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input int imm);
    logic [31:0] imm_bits;
    imm_bits = imm;
    return {imm_bits[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // Unused words decode as no-ops, pattern mixes every address bit
  function automatic logic [31:0] read_imem(input logic [31:0] addr);
    int idx;
    idx = (addr - `BLIMP_RESET_PC) >> 2;
    if (addr >= `BLIMP_RESET_PC && idx < prog.size()) begin
      return prog[idx];
    end
    return ((addr * 32'h9e37_79b1) & ~32'h7f) | 32'h7f;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic void ref_step(input logic [31:0] pc, input logic [31:0] inst,
                                   inout logic [31:0] regs [`BLIMP_NUM_REGS],
                                   output logic [4:0] waddr, output logic [31:0] wdata,
                                   output logic wen);
    logic [31:0] a;
    logic [31:0] b;
    logic        legal;
    a     = regs[inst[19:15]];
    b     = regs[inst[24:20]];
    legal = 1'b1;
    wdata = '0;
    if (inst[6:0] == 7'b0110011) begin
      case ({inst[31:25], inst[14:12]})
        {7'h00, 3'h0}: wdata = a + b;
        {7'h20, 3'h0}: wdata = a - b;
        {7'h00, 3'h7}: wdata = a & b;
        {7'h00, 3'h6}: wdata = a | b;
        {7'h00, 3'h4}: wdata = a ^ b;
        {7'h00, 3'h2}: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // Low half of the product
        {7'h01, 3'h0}: wdata = a * b;
        default:       legal = 1'b0;
      endcase
    end else if (inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000) begin
      wdata = a + {{20{inst[31]}}, inst[31:20]};
    end else begin
      legal = 1'b0;
    end
    waddr = inst[11:7];
    wen   = legal && (inst[11:7] != 5'd0);
    if (wen) begin
      regs[waddr] = wdata;
    end
  endfunction

  // --------------------
  // Program construction
  // --------------------
  task automatic close_test(input string name);
    test_names.push_back(name);
    test_last.push_back(prog.size() - 1);
  endtask

  task automatic build_program();
    int kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    // First commits and pc order
    prog.push_back(addi_word(1, 0, 5));
    prog.push_back(addi_word(2, 0, -3));
    prog.push_back(addi_word(3, 0, 100));
    close_test("reset_first_commit");
    // Dependent ALU chain
    prog.push_back(rtype_word(7'h00, 2, 1, 3'h0, 4));
    prog.push_back(rtype_word(7'h20, 1, 4, 3'h0, 5));
    prog.push_back(rtype_word(7'h00, 3, 5, 3'h7, 6));
    prog.push_back(rtype_word(7'h00, 4, 6, 3'h6, 7));
    prog.push_back(rtype_word(7'h00, 5, 7, 3'h4, 1));
    prog.push_back(rtype_word(7'h00, 3, 1, 3'h2, 2));
    prog.push_back(rtype_word(7'h00, 4, 5, 3'h2, 3));
    prog.push_back(addi_word(4, 3, -1000));
    close_test("alu_dependent_chain");
    // Mul overtaken by independent ALU work
    prog.push_back(addi_word(1, 0, 123));
    prog.push_back(addi_word(2, 0, -45));
    prog.push_back(rtype_word(7'h01, 2, 1, 3'h0, 3));
    prog.push_back(addi_word(4, 0, 1));
    prog.push_back(rtype_word(7'h00, 1, 1, 3'h0, 5));
    prog.push_back(rtype_word(7'h00, 1, 2, 3'h4, 6));
    prog.push_back(rtype_word(7'h00, 5, 4, 3'h6, 7));
    close_test("mul_then_independent");
    // Mul feeding consumers, negative and overflowing operands
    prog.push_back(addi_word(1, 0, -7));
    prog.push_back(addi_word(2, 0, 2047));
    prog.push_back(rtype_word(7'h01, 2, 1, 3'h0, 3));
    prog.push_back(rtype_word(7'h00, 1, 3, 3'h0, 4));
    prog.push_back(rtype_word(7'h01, 2, 2, 3'h0, 5));
    prog.push_back(rtype_word(7'h01, 5, 5, 3'h0, 6));
    prog.push_back(rtype_word(7'h01, 1, 6, 3'h0, 7));
    prog.push_back(rtype_word(7'h20, 6, 7, 3'h0, 4));
    close_test("mul_dependent");
    // x0 targets and undecodable words
    prog.push_back(addi_word(0, 1, 5));
    prog.push_back(rtype_word(7'h01, 2, 1, 3'h0, 0));
    prog.push_back(32'hffff_ffff);
    prog.push_back(32'h0000_0000);
    prog.push_back(rtype_word(7'h20, 2, 1, 3'h7, 9));
    prog.push_back(rtype_word(7'h00, 0, 0, 3'h0, 5));
    prog.push_back(rtype_word(7'h00, 2, 0, 3'h6, 6));
    prog.push_back(addi_word(7, 0, 0));
    close_test("x0_and_illegal");
    // Random mix over x0 to x7
    for (int i = 0; i < 64; i++) begin
      kind = $urandom_range(7, 0);
      rd   = 5'($urandom_range(7, 0));
      rs1  = 5'($urandom_range(7, 0));
      rs2  = 5'($urandom_range(7, 0));
      case (kind)
        0:       prog.push_back(rtype_word(7'h00, rs2, rs1, 3'h0, rd));
        1:       prog.push_back(rtype_word(7'h20, rs2, rs1, 3'h0, rd));
        2:       prog.push_back(rtype_word(7'h00, rs2, rs1, 3'h7, rd));
        3:       prog.push_back(rtype_word(7'h00, rs2, rs1, 3'h6, rd));
        4:       prog.push_back(rtype_word(7'h00, rs2, rs1, 3'h4, rd));
        5:       prog.push_back(rtype_word(7'h00, rs2, rs1, 3'h2, rd));
        6:       prog.push_back(addi_word(rd, rs1, int'($urandom_range(4095, 0))));
        default: prog.push_back(rtype_word(7'h01, rs2, rs1, 3'h0, rd));
      endcase
    end
    close_test("random_program");
  endtask

  // --------------------
  // Clock
  // --------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory model, about 75 percent request ready, 0 to 3 cycle response delay
  always @(posedge clk) begin
    if (rst) begin
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
      resp_busy = 1'b0;
      pend_addr.delete();
      pend_delay.delete();
    end else begin
      if (mem_resp_val && mem_resp_rdy) begin
        resp_busy = 1'b0;
      end
      if (mem_req_val && mem_req_rdy) begin
        pend_addr.push_back(mem_req_addr);
        pend_delay.push_back($urandom_range(3, 0));
      end
      if (!resp_busy && pend_addr.size() != 0) begin
        if (pend_delay[0] == 0) begin
          mem_resp_data <= read_imem(pend_addr.pop_front());
          void'(pend_delay.pop_front());
          resp_busy = 1'b1;
        end else begin
          pend_delay[0] = pend_delay[0] - 1;
        end
      end
      // Response holds until decode takes it
      mem_resp_val <= resp_busy;
      mem_req_rdy  <= ($urandom_range(3, 0) != 0);
    end
  end

  // --------------------
  // Checker
  // --------------------
  task automatic report_mismatch(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("MISMATCH %s %s at commit %0d: expected %h actual %h",
             test_names[cur_test], field, commit_count, exp_v, act_v);
    test_errors++;
  endtask

  task automatic finish_test();
    $display("Test %s: %s, %0d errors", test_names[cur_test],
             (test_errors == 0) ? "PASS" : "FAIL", test_errors);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    test_errors = 0;
    cur_test++;
    if (cur_test == test_names.size()) begin
      done = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && !done) begin
      assert (!$isunknown(trace_val)) else begin
        $display("ERROR %s: trace_val is unknown after reset", test_names[cur_test]);
        test_errors++;
      end
      if (trace_val === 1'b1) begin
        exp_pc = `BLIMP_RESET_PC + commit_count * 4;
        ref_step(exp_pc, prog[commit_count], ref_regs, exp_waddr, exp_wdata, exp_wen);
        assert (trace_pc === exp_pc) else report_mismatch("pc", exp_pc, trace_pc);
        assert (trace_waddr === exp_waddr)
          else report_mismatch("waddr", 32'(exp_waddr), 32'(trace_waddr));
        assert (trace_wen === exp_wen)
          else report_mismatch("wen", 32'(exp_wen), 32'(trace_wen));
        // Data matters only when the register is written
        assert (!exp_wen || trace_wdata === exp_wdata)
          else report_mismatch("wdata", exp_wdata, trace_wdata);
        if (commit_count == test_last[cur_test]) begin
          finish_test();
        end
        commit_count++;
      end
    end
  end

  // Timeout, 40 cycles per instruction
  always @(posedge clk) begin
    if (!rst && !done) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("Timeout: commits stopped after %0d of %0d instructions",
                 commit_count, prog.size());
        $display("Regression failed");
        $finish;
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(32'h3705));
    rst           = 1'b1;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    resp_busy     = 1'b0;
    commit_count  = 0;
    cur_test      = 0;
    test_errors   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    cycles        = 0;
    done          = 1'b0;
    for (int i = 0; i < `BLIMP_NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    build_program();
    cycle_limit = prog.size() * 40;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    @(posedge clk);
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: source/blimp_top.sv
// --------------------
// blimp core top level
// Fetch, decode/issue, ALU and mul pipes, commit
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module blimp_top (
  input  logic                            clk,
  input  logic                            rst,
  // Instruction memory
  output logic                            mem_req_val,
  input  logic                            mem_req_rdy,
  output logic [`BLIMP_XLEN-1:0]          mem_req_addr,
  input  logic                            mem_resp_val,
  output logic                            mem_resp_rdy,
  input  logic [`BLIMP_XLEN-1:0]          mem_resp_data,
  // Instruction trace
  output logic                            trace_val,
  output logic [`BLIMP_XLEN-1:0]          trace_pc,
  output logic [`BLIMP_REG_ADDR_BITS-1:0] trace_waddr,
  output logic [`BLIMP_XLEN-1:0]          trace_wdata,
  output logic                            trace_wen
);

  import blimp_pkg::*;

  // --------------------
  // Unit-to-unit wires
  // --------------------
  logic                            f_val, f_rdy;
  logic [`BLIMP_XLEN-1:0]          f_pc, f_inst;
  logic                            alu_issue_val, mul_issue_val;
  issue_t                          alu_issue, mul_issue;
  logic                            alu_result_val, mul_result_val;
  result_t                         alu_result, mul_result;
  logic                            commit_val, commit_wen;
  logic [`BLIMP_XLEN-1:0]          commit_pc, commit_wdata;
  logic [`BLIMP_REG_ADDR_BITS-1:0] commit_waddr;

  // Trace mirrors commit
  assign trace_val   = commit_val;
  assign trace_pc    = commit_pc;
  assign trace_waddr = commit_waddr;
  assign trace_wdata = commit_wdata;
  assign trace_wen   = commit_wen;

  // --------------------
  // Units
  // --------------------
  fetch_unit fu (
    .*
  );

  decode_issue_unit diu (
    .*
  );

  alu_unit alu_xu (
    .clk        (clk),
    .rst        (rst),
    .issue_val  (alu_issue_val),
    .issue      (alu_issue),
    .result_val (alu_result_val),
    .result     (alu_result)
  );

  multiplier_unit mul_xu (
    .clk        (clk),
    .rst        (rst),
    .issue_val  (mul_issue_val),
    .issue      (mul_issue),
    .result_val (mul_result_val),
    .result     (mul_result)
  );

  writeback_commit_unit wcu (
    .*
  );

endmodule

// File: writeback_commit/writeback_commit_unit.sv
// --------------------
// Writeback and commit unit
// Reorder buffer by sequence number, in-order commit
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module writeback_commit_unit (
  input  logic                            clk,
  input  logic                            rst,
  // From execute pipes
  input  logic                            alu_result_val,
  input  blimp_pkg::result_t              alu_result,
  input  logic                            mul_result_val,
  input  blimp_pkg::result_t              mul_result,
  // Commit
  output logic                            commit_val,
  output logic [`BLIMP_XLEN-1:0]          commit_pc,
  output logic [`BLIMP_REG_ADDR_BITS-1:0] commit_waddr,
  output logic [`BLIMP_XLEN-1:0]          commit_wdata,
  output logic                            commit_wen
);

  import blimp_pkg::*;

  localparam int NUM_SLOTS = 1 << `BLIMP_SEQ_NUM_BITS;

  result_t                        rob [NUM_SLOTS];
  logic [NUM_SLOTS-1:0]           rob_full;
  logic [`BLIMP_SEQ_NUM_BITS-1:0] head;
  logic                           head_ready;

  // Only slots filled on an earlier edge count
  assign head_ready = rob_full[head];

  // --------------------
  // Slot bookkeeping
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rob_full   <= '0;
      head       <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;
      if (head_ready) begin
        rob_full[head] <= 1'b0;
        head           <= head + 1'b1;
      end
      // Arrivals never hit the slot being retired
      if (alu_result_val) begin
        rob_full[alu_result.seq_num] <= 1'b1;
      end
      if (mul_result_val) begin
        rob_full[mul_result.seq_num] <= 1'b1;
      end
    end
  end

  // Payload storage and commit registers
  always_ff @(posedge clk) begin
    if (alu_result_val) begin
      rob[alu_result.seq_num] <= alu_result;
    end
    if (mul_result_val) begin
      rob[mul_result.seq_num] <= mul_result;
    end
    commit_pc    <= rob[head].pc;
    commit_waddr <= rob[head].waddr;
    commit_wdata <= rob[head].wdata;
    commit_wen   <= rob[head].wen;
  end

endmodule

// File: source/multiplier_unit.sv
// --------------------
// Three-stage multiplier pipe
// Low 32 bits of the product
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module multiplier_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_val,
  input  blimp_pkg::issue_t   issue,
  output logic                result_val,
  output blimp_pkg::result_t  result
);

  import blimp_pkg::*;

  // Stage 1 captured operands
  logic                   s1_val;
  issue_t                 s1;
  // Stage 2 tags with the low partial product in wdata
  logic                   s2_val;
  result_t                s2_meta;
  logic [15:0]            s2_hi;

  // --------------------
  // Valid chain
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val     <= 1'b0;
      s2_val     <= 1'b0;
      result_val <= 1'b0;
    end else begin
      s1_val     <= issue_val;
      s2_val     <= s1_val;
      result_val <= s2_val;
    end
  end

  always_ff @(posedge clk) begin
    s1 <= issue;
    // Full a * b[15:0] term and a 16-bit upper half term
    s2_meta.seq_num <= s1.seq_num;
    s2_meta.pc      <= s1.pc;
    s2_meta.waddr   <= s1.waddr;
    s2_meta.wdata   <= s1.op_a * s1.op_b[15:0];
    s2_meta.wen     <= s1.wen;
    s2_hi           <= s1.op_a[15:0] * s1.op_b[31:16];
    // Final sum and result
    result       <= s2_meta;
    result.wdata <= s2_meta.wdata + {s2_hi, 16'b0};
  end

endmodule

// File: source/alu_unit.sv
// --------------------
// Single-cycle ALU pipe
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module alu_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_val,
  input  blimp_pkg::issue_t   issue,
  output logic                result_val,
  output blimp_pkg::result_t  result
);

  import blimp_pkg::*;

  logic [`BLIMP_XLEN-1:0] alu_out;

  always_comb begin
    case (issue.op)
      op_add:  alu_out = issue.op_a + issue.op_b;
      op_sub:  alu_out = issue.op_a - issue.op_b;
      op_and:  alu_out = issue.op_a & issue.op_b;
      op_or:   alu_out = issue.op_a | issue.op_b;
      op_xor:  alu_out = issue.op_a ^ issue.op_b;
      // Signed compare
      op_slt:  alu_out = {{(`BLIMP_XLEN-1){1'b0}},
                          ($signed(issue.op_a) < $signed(issue.op_b))};
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_val <= 1'b0;
    end else begin
      result_val <= issue_val;
    end
  end

  // Result payload with its tags
  always_ff @(posedge clk) begin
    result.seq_num <= issue.seq_num;
    result.pc      <= issue.pc;
    result.waddr   <= issue.waddr;
    result.wdata   <= alu_out;
    result.wen     <= issue.wen;
  end

endmodule

// File: decode_issue/decode_issue_unit.sv
// --------------------
// Decode and issue unit
// RV32 subset decoder, register file, scoreboard
// In-flight limit, sequence numbering, pipe routing
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module decode_issue_unit (
  input  logic                            clk,
  input  logic                            rst,
  // From fetch
  input  logic                            f_val,
  output logic                            f_rdy,
  input  logic [`BLIMP_XLEN-1:0]          f_pc,
  input  logic [`BLIMP_XLEN-1:0]          f_inst,
  // To execute pipes
  output logic                            alu_issue_val,
  output blimp_pkg::issue_t               alu_issue,
  output logic                            mul_issue_val,
  output blimp_pkg::issue_t               mul_issue,
  // From commit
  input  logic                            commit_val,
  input  logic [`BLIMP_REG_ADDR_BITS-1:0] commit_waddr,
  input  logic [`BLIMP_XLEN-1:0]          commit_wdata,
  input  logic                            commit_wen
);

  import blimp_pkg::*;

  localparam int NUM_SLOTS = 1 << `BLIMP_SEQ_NUM_BITS;

  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [`BLIMP_REG_ADDR_BITS-1:0] rs1, rs2, rd;
  logic [`BLIMP_XLEN-1:0]          imm;
  logic [`BLIMP_XLEN-1:0]          rs1_val, rs2_val;
  alu_op_t                         op;
  logic                            is_mul, uses_rs1, uses_rs2, use_imm, dec_wen;
  logic                            hazard, stall, fire;

  logic [`BLIMP_XLEN-1:0]          regs [`BLIMP_NUM_REGS];
  logic [`BLIMP_NUM_REGS-1:0]      busy;
  logic [`BLIMP_SEQ_NUM_BITS:0]    inflight;
  logic [`BLIMP_SEQ_NUM_BITS-1:0]  seq_num;
  // Bit 1 means a mul went out two cycles ago
  logic [1:0]                      mul_hist;

  // --------------------
  // Decode
  // --------------------
  assign opcode = f_inst[6:0];
  assign rd     = f_inst[11:7];
  assign funct3 = f_inst[14:12];
  assign rs1    = f_inst[19:15];
  assign rs2    = f_inst[24:20];
  assign funct7 = f_inst[31:25];
  assign imm    = {{(`BLIMP_XLEN-12){f_inst[31]}}, f_inst[31:20]};

  always_comb begin
    // Unknown encodings fall through as a no-op
    op       = op_nop;
    is_mul   = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    use_imm  = 1'b0;
    dec_wen  = 1'b0;
    if (opcode == 7'b0110011) begin
      uses_rs1 = 1'b1;
      uses_rs2 = 1'b1;
      dec_wen  = 1'b1;
      case ({funct7, funct3})
        {7'b0000000, 3'b000}: op = op_add;
        {7'b0100000, 3'b000}: op = op_sub;
        {7'b0000000, 3'b111}: op = op_and;
        {7'b0000000, 3'b110}: op = op_or;
        {7'b0000000, 3'b100}: op = op_xor;
        {7'b0000000, 3'b010}: op = op_slt;
        {7'b0000001, 3'b000}: is_mul = 1'b1;
        default: begin
          uses_rs1 = 1'b0;
          uses_rs2 = 1'b0;
          dec_wen  = 1'b0;
        end
      endcase
    end else if (opcode == 7'b0010011 && funct3 == 3'b000) begin
      // addi
      op       = op_add;
      uses_rs1 = 1'b1;
      use_imm  = 1'b1;
      dec_wen  = 1'b1;
    end
    // x0 is never written
    if (rd == '0) begin
      dec_wen = 1'b0;
    end
  end

  // Operand read, x0 reads zero
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  // --------------------
  // Issue control
  // --------------------
  assign hazard = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) ||
                  (dec_wen && busy[rd]);
  // ALU result would land with the mul from two cycles back
  assign stall  = hazard || (inflight == NUM_SLOTS) || (!is_mul && mul_hist[1]);
  assign f_rdy  = f_val && !stall;
  assign fire   = f_rdy;

  assign alu_issue_val = fire && !is_mul;
  assign mul_issue_val = fire && is_mul;

  always_comb begin
    alu_issue.seq_num = seq_num;
    alu_issue.pc      = f_pc;
    alu_issue.op      = op;
    alu_issue.op_a    = rs1_val;
    alu_issue.op_b    = use_imm ? imm : rs2_val;
    alu_issue.waddr   = rd;
    alu_issue.wen     = dec_wen;
    // Same payload, the mul pipe ignores op
    mul_issue         = alu_issue;
  end

  // --------------------
  // State
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= '0;
      inflight <= '0;
      seq_num  <= '0;
      mul_hist <= '0;
      for (int i = 0; i < `BLIMP_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      mul_hist <= {mul_hist[0], mul_issue_val};
      // Commit writes back and frees its destination
      if (commit_val && commit_wen) begin
        regs[commit_waddr] <= commit_wdata;
        busy[commit_waddr] <= 1'b0;
      end
      if (fire) begin
        seq_num <= seq_num + 1'b1;
        if (dec_wen) begin
          busy[rd] <= 1'b1;
        end
      end
      // In-flight count, one in and one out per cycle at most
      case ({fire, commit_val})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

endmodule

// File: source/fetch_unit.sv
// --------------------
// Fetch unit
// Sequential PC, one outstanding instruction memory request
// --------------------
`timescale 1ns/1ps
`include "blimp_settings.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst,
  // Instruction memory request
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  output logic [`BLIMP_XLEN-1:0] mem_req_addr,
  // Instruction memory response
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy,
  input  logic [`BLIMP_XLEN-1:0] mem_resp_data,
  // To decode
  output logic                   f_val,
  input  logic                   f_rdy,
  output logic [`BLIMP_XLEN-1:0] f_pc,
  output logic [`BLIMP_XLEN-1:0] f_inst
);

  logic [`BLIMP_XLEN-1:0] pc;
  logic                   req_val;
  logic                   outstanding;
  logic                   resp_xfer;

  // PC stays put until its response is accepted
  assign mem_req_val  = req_val;
  assign mem_req_addr = pc;

  // Response passes straight through to decode
  assign mem_resp_rdy = f_rdy;
  assign f_val        = mem_resp_val;
  assign f_pc         = pc;
  assign f_inst       = mem_resp_data;
  assign resp_xfer    = mem_resp_val && mem_resp_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= `BLIMP_RESET_PC;
      req_val     <= 1'b0;
      outstanding <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      // Request taken, wait for its response
      req_val     <= 1'b0;
      outstanding <= 1'b1;
    end else if (resp_xfer) begin
      // Next sequential request
      outstanding <= 1'b0;
      req_val     <= 1'b1;
      pc          <= pc + `BLIMP_XLEN'd4;
    end else if (!req_val && !outstanding) begin
      // Idle right after reset
      req_val <= 1'b1;
    end
  end

endmodule

// File: common/blimp_pkg.sv
// --------------------
// Shared types for the blimp core
// ALU operation encoding, issue and result payloads
// --------------------
`include "blimp_settings.svh"

package blimp_pkg;

  // ALU operation select
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_nop
  } alu_op_t;

  // Decode to execute pipe
  typedef struct packed {
    logic [`BLIMP_SEQ_NUM_BITS-1:0]  seq_num;
    logic [`BLIMP_XLEN-1:0]          pc;
    alu_op_t                         op;
    logic [`BLIMP_XLEN-1:0]          op_a;
    logic [`BLIMP_XLEN-1:0]          op_b;
    logic [`BLIMP_REG_ADDR_BITS-1:0] waddr;
    logic                            wen;
  } issue_t;

  // Execute pipe to commit
  typedef struct packed {
    logic [`BLIMP_SEQ_NUM_BITS-1:0]  seq_num;
    logic [`BLIMP_XLEN-1:0]          pc;
    logic [`BLIMP_REG_ADDR_BITS-1:0] waddr;
    logic [`BLIMP_XLEN-1:0]          wdata;
    logic                            wen;
  } result_t;

endpackage

// File: common/blimp_settings.svh
// --------------------
// Global sizing macros for the blimp core
// Datapath width, register count, reorder depth, reset PC
// --------------------
`ifndef BLIMP_SETTINGS_SVH
`define BLIMP_SETTINGS_SVH

// Data and address width
`define BLIMP_XLEN 32
// Architectural registers, x0 hardwired to zero
`define BLIMP_NUM_REGS 32
`define BLIMP_REG_ADDR_BITS 5
// Sequence number width, sets reorder slots and in-flight limit
`define BLIMP_SEQ_NUM_BITS 5
// First fetch address
`define BLIMP_RESET_PC 32'h200

`endif
